// ==== conv_macros.svh ====
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Image geometry.
`define CONV_IMG_W 12
`define CONV_IMG_H 12

// Kernel side, in pixels.
`define CONV_K 5

// Pixels and weights share one width.
`define CONV_PIX_W 6

// Byte address into the 144-entry pixel buffer.
`define CONV_ADDR_W 8

// Holds 25 * 63 * 63 without overflow.
`define CONV_SUM_W 18

`endif

// ==== conv_pkg.sv ====
`default_nettype none

package conv_pkg;

  // ********************************************************************
  // Host command opcodes
  // ********************************************************************
  typedef enum logic [1:0] {
    OP_WR_PIXEL  = 2'd0,  // Pixel into buffer.
    OP_WR_KERNEL = 2'd1,  // Weight into kernel register.
    OP_RD_PIXEL  = 2'd2,  // Pixel read-back.
    OP_START     = 2'd3   // Begin a run.
  } cmd_op_t;

  // ********************************************************************
  // Window fetcher states
  // ********************************************************************
  typedef enum logic [1:0] {
    FS_IDLE = 2'd0,
    FS_READ = 2'd1,  // Gathering 25 taps.
    FS_EMIT = 2'd2   // Window handed to MAC.
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== pixel_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

// One requester's path into the pixel buffer.
interface pixel_bus_if;

  logic                    req;
  logic                    we;
  logic [`CONV_ADDR_W-1:0] addr;
  logic [`CONV_PIX_W-1:0]  wdata;
  logic                    gnt;
  logic [`CONV_PIX_W-1:0]  rdata;  // Valid one cycle after gnt.

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rdata
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rdata
  );

endinterface

`default_nettype wire

// ==== pixel_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module pixel_buffer (
  input wire           clk,
  pixel_bus_if.arbiter host,
  pixel_bus_if.arbiter fetch
);

  localparam int DEPTH = `CONV_IMG_W * `CONV_IMG_H;

  logic [`CONV_PIX_W-1:0]  mem [DEPTH];

  logic                    acc_en;
  logic                    acc_we;
  logic [`CONV_ADDR_W-1:0] acc_addr;
  logic [`CONV_PIX_W-1:0]  acc_wdata;
  logic [`CONV_PIX_W-1:0]  rd_word;

  // ********************************************************************
  // Fixed priority, host first
  // ********************************************************************
  assign host.gnt  = host.req;               // Host never waits.
  assign fetch.gnt = fetch.req & ~host.req;

  // Single port, muxed to the winner.
  always_comb begin
    acc_en = host.req | fetch.req;
    if (host.req) begin
      acc_we    = host.we;
      acc_addr  = host.addr;
      acc_wdata = host.wdata;
    end else begin
      acc_we    = fetch.we;
      acc_addr  = fetch.addr;
      acc_wdata = fetch.wdata;
    end
  end

  assign rd_word = mem[acc_addr];

  // ********************************************************************
  // Storage and registered read data
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (acc_en && acc_we && (acc_addr < `CONV_ADDR_W'(DEPTH))) begin
      mem[acc_addr] <= acc_wdata;
    end
    if (host.gnt) begin
      host.rdata <= rd_word;
    end
    if (fetch.gnt) begin
      fetch.rdata <= rd_word;  // Only the winner's data moves.
    end
  end

endmodule

`default_nettype wire

// ==== host_cmd_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module host_cmd_decoder (
  input wire                     clk,
  input wire                     arst_n,
  input wire                     cmd_valid,
  input wire conv_pkg::cmd_op_t  cmd_op,
  input wire [`CONV_ADDR_W-1:0]  cmd_addr,
  input wire [`CONV_PIX_W-1:0]   cmd_data,
  input wire                     busy,
  pixel_bus_if.requester         bus,
  output logic [`CONV_K*`CONV_K*`CONV_PIX_W-1:0] weights,
  output logic                   start,
  output logic                   rd_valid,
  output logic [`CONV_PIX_W-1:0] rd_data
);

  localparam int NTAP = `CONV_K * `CONV_K;

  logic [NTAP-1:0][`CONV_PIX_W-1:0] kern_q;

  logic is_wr_pix;
  logic is_wr_kern;
  logic is_rd_pix;

  // ********************************************************************
  // Command decode
  // ********************************************************************
  assign is_wr_pix  = cmd_valid && (cmd_op == conv_pkg::OP_WR_PIXEL);
  assign is_wr_kern = cmd_valid && (cmd_op == conv_pkg::OP_WR_KERNEL);
  assign is_rd_pix  = cmd_valid && (cmd_op == conv_pkg::OP_RD_PIXEL);

  // Starts during a run are dropped.
  assign start = cmd_valid && (cmd_op == conv_pkg::OP_START) && !busy;

  // Pixel accesses go out in the strobe cycle.
  assign bus.req   = is_wr_pix | is_rd_pix;
  assign bus.we    = is_wr_pix;
  assign bus.addr  = cmd_addr;
  assign bus.wdata = cmd_data;

  assign weights = kern_q;
  assign rd_data = bus.rdata;  // Buffer registers it already.

  // ********************************************************************
  // Kernel registers and read-back flag
  // ********************************************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      kern_q   <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= is_rd_pix & bus.gnt;
      if (is_wr_kern && (cmd_addr < `CONV_ADDR_W'(NTAP))) begin
        kern_q[cmd_addr[4:0]] <= cmd_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== window_fetcher.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module window_fetcher (
  input wire             clk,
  input wire             arst_n,
  input wire             start,
  pixel_bus_if.requester bus,
  output logic           busy,
  output logic           window_valid,
  output logic           window_last,
  output logic [`CONV_K*`CONV_K*`CONV_PIX_W-1:0] window
);

  localparam int NTAP  = `CONV_K * `CONV_K;
  localparam int OUT_W = `CONV_IMG_W - `CONV_K + 1;
  localparam int OUT_H = `CONV_IMG_H - `CONV_K + 1;
  localparam int PW    = $clog2(OUT_W > OUT_H ? OUT_W : OUT_H);
  localparam int TW    = $clog2(`CONV_K);
  localparam int CW    = $clog2(NTAP);

  conv_pkg::fetch_state_t state_q;

  logic [PW-1:0] row_q;
  logic [PW-1:0] col_q;
  logic [TW-1:0] trow_q;
  logic [TW-1:0] tcol_q;
  logic          issued_q;  // All taps requested.
  logic [CW-1:0] recv_q;    // Taps returned so far.
  logic          pend_q;    // Read data due this cycle.
  logic          bus_take;
  logic          last_pos;

  logic [NTAP-1:0][`CONV_PIX_W-1:0] window_q;
  logic [`CONV_ADDR_W-1:0]          pix_row;
  logic [`CONV_ADDR_W-1:0]          pix_col;

  // ********************************************************************
  // Read requests
  // ********************************************************************
  assign bus.req   = (state_q == conv_pkg::FS_READ) && !issued_q;
  assign bus.we    = 1'b0;
  assign bus.wdata = '0;
  assign bus_take  = bus.req & bus.gnt;

  always_comb begin
    pix_row  = `CONV_ADDR_W'(row_q) + `CONV_ADDR_W'(trow_q);
    pix_col  = `CONV_ADDR_W'(col_q) + `CONV_ADDR_W'(tcol_q);
    bus.addr = pix_row * `CONV_ADDR_W'(`CONV_IMG_W) + pix_col;
  end

  assign last_pos = (row_q == PW'(OUT_H - 1)) && (col_q == PW'(OUT_W - 1));

  assign busy         = (state_q != conv_pkg::FS_IDLE);
  assign window_valid = (state_q == conv_pkg::FS_EMIT);
  assign window_last  = window_valid && last_pos;
  assign window       = window_q;

  // ********************************************************************
  // Control FSM
  // ********************************************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= conv_pkg::FS_IDLE;
      row_q    <= '0;
      col_q    <= '0;
      trow_q   <= '0;
      tcol_q   <= '0;
      issued_q <= 1'b0;
      recv_q   <= '0;
      pend_q   <= 1'b0;
    end else begin
      pend_q <= bus_take;
      case (state_q)
        conv_pkg::FS_IDLE: begin
          if (start) begin
            row_q    <= '0;
            col_q    <= '0;
            trow_q   <= '0;
            tcol_q   <= '0;
            issued_q <= 1'b0;
            recv_q   <= '0;
            state_q  <= conv_pkg::FS_READ;
          end
        end
        conv_pkg::FS_READ: begin
          if (bus_take) begin  // Step tap in raster order.
            if (tcol_q == TW'(`CONV_K - 1)) begin
              tcol_q <= '0;
              if (trow_q == TW'(`CONV_K - 1)) issued_q <= 1'b1;
              else trow_q <= trow_q + 1'b1;
            end else begin
              tcol_q <= tcol_q + 1'b1;
            end
          end
          if (pend_q) begin
            recv_q <= recv_q + 1'b1;
            if (recv_q == CW'(NTAP - 1)) state_q <= conv_pkg::FS_EMIT;
          end
        end
        conv_pkg::FS_EMIT: begin
          trow_q   <= '0;
          tcol_q   <= '0;
          issued_q <= 1'b0;
          recv_q   <= '0;
          if (last_pos) begin
            state_q <= conv_pkg::FS_IDLE;
          end else begin
            if (col_q == PW'(OUT_W - 1)) begin
              col_q <= '0;
              row_q <= row_q + 1'b1;
            end else begin
              col_q <= col_q + 1'b1;
            end
            state_q <= conv_pkg::FS_READ;
          end
        end
        default: state_q <= conv_pkg::FS_IDLE;
      endcase
    end
  end

  // First tap ends up in slot 0.
  always_ff @(posedge clk) begin
    if (pend_q) window_q <= {bus.rdata, window_q[NTAP-1:1]};
  end

endmodule

`default_nettype wire

// ==== conv5x5_mac.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module conv5x5_mac (
  input wire                                   clk,
  input wire                                   arst_n,
  input wire                                   window_valid,
  input wire                                   window_last,
  input wire [`CONV_K*`CONV_K*`CONV_PIX_W-1:0] window,
  input wire [`CONV_K*`CONV_K*`CONV_PIX_W-1:0] weights,
  output logic                                 result_valid,
  output logic [`CONV_SUM_W-1:0]               result_data,
  output logic                                 done
);

  localparam int NTAP   = `CONV_K * `CONV_K;
  localparam int PROD_W = 2 * `CONV_PIX_W;
  localparam int LEVELS = $clog2(NTAP);  // Five for 25 taps.

  logic [PROD_W-1:0]      prod [NTAP];
  logic [`CONV_SUM_W-1:0] tree [LEVELS+1][NTAP];

  // ********************************************************************
  // Multipliers
  // ********************************************************************
  always_comb begin
    for (int i = 0; i < NTAP; i++) begin
      prod[i] = window[i*`CONV_PIX_W +: `CONV_PIX_W] * weights[i*`CONV_PIX_W +: `CONV_PIX_W];
    end
  end

  // ********************************************************************
  // Adder tree
  // ********************************************************************
  // Pairs add, an odd node passes through. 25, 13, 7, 4, 2, 1.
  always_comb begin
    int cnt;
    cnt = NTAP;
    for (int n = 0; n < NTAP; n++) begin
      tree[0][n] = `CONV_SUM_W'(prod[n]);
    end
    for (int lv = 1; lv <= LEVELS; lv++) begin
      for (int n = 0; n < NTAP; n++) begin
        if (2*n + 1 < cnt) begin
          tree[lv][n] = tree[lv-1][2*n] + tree[lv-1][2*n+1];
        end else if (2*n < cnt) begin
          tree[lv][n] = tree[lv-1][2*n];
        end else begin
          tree[lv][n] = '0;
        end
      end
      cnt = (cnt + 1) / 2;
    end
  end

  // ********************************************************************
  // Output register
  // ********************************************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
      result_data  <= '0;
      done         <= 1'b0;
    end else begin
      result_valid <= window_valid;
      done         <= window_valid & window_last;  // Flags 64th result.
      if (window_valid) result_data <= tree[LEVELS][0];
    end
  end

endmodule

`default_nettype wire

// ==== conv_engine_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module conv_engine_top (
  input wire                      clk,
  input wire                      arst_n,
  input wire                      cmd_valid,
  input wire conv_pkg::cmd_op_t   cmd_op,
  input wire [`CONV_ADDR_W-1:0]   cmd_addr,
  input wire [`CONV_PIX_W-1:0]    cmd_data,
  output logic                    rd_valid,
  output logic [`CONV_PIX_W-1:0]  rd_data,
  output logic                    busy,
  output logic                    result_valid,
  output logic [`CONV_SUM_W-1:0]  result_data,
  output logic                    done
);

  localparam int WIN_W = `CONV_K * `CONV_K * `CONV_PIX_W;

  logic             start;
  logic [WIN_W-1:0] weights;
  logic [WIN_W-1:0] window;
  logic             window_valid;
  logic             window_last;

  // Two peers on the one pixel buffer.
  pixel_bus_if host_bus ();
  pixel_bus_if fetch_bus ();

  host_cmd_decoder u_decoder (
    .clk      (clk),
    .arst_n   (arst_n),
    .cmd_valid(cmd_valid),
    .cmd_op   (cmd_op),
    .cmd_addr (cmd_addr),
    .cmd_data (cmd_data),
    .busy     (busy),
    .bus      (host_bus.requester),
    .weights  (weights),
    .start    (start),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  window_fetcher u_fetcher (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .bus         (fetch_bus.requester),
    .busy        (busy),
    .window_valid(window_valid),
    .window_last (window_last),
    .window      (window)
  );

  pixel_buffer u_buffer (
    .clk  (clk),
    .host (host_bus.arbiter),
    .fetch(fetch_bus.arbiter)
  );

  conv5x5_mac u_mac (
    .clk         (clk),
    .arst_n      (arst_n),
    .window_valid(window_valid),
    .window_last (window_last),
    .window      (window),
    .weights     (weights),
    .result_valid(result_valid),
    .result_data (result_data),
    .done        (done)
  );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;  // 20 ns period.
  end

  // Release a little after an edge.
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== conv_engine_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module conv_engine_tb;

  localparam int OUT_W      = `CONV_IMG_W - `CONV_K + 1;
  localparam int OUT_H      = `CONV_IMG_H - `CONV_K + 1;
  localparam int OUT_N      = OUT_W * OUT_H;
  localparam int NPIX       = `CONV_IMG_W * `CONV_IMG_H;
  localparam int NTAP       = `CONV_K * `CONV_K;
  localparam int RUN_CYCLES = OUT_N * 32 + 200;  // About 27 per window plus host traffic.
  localparam int MAX_CYCLES = 2 * (5 * RUN_CYCLES + 4 * (NPIX + NTAP));

  logic                    clk;
  logic                    arst_n;
  logic                    cmd_valid;
  conv_pkg::cmd_op_t       cmd_op;
  logic [`CONV_ADDR_W-1:0] cmd_addr;
  logic [`CONV_PIX_W-1:0]  cmd_data;
  logic                    rd_valid;
  logic [`CONV_PIX_W-1:0]  rd_data;
  logic                    busy;
  logic                    result_valid;
  logic [`CONV_SUM_W-1:0]  result_data;
  logic                    done;

  logic [`CONV_PIX_W-1:0] pix_model [NPIX];
  logic [`CONV_PIX_W-1:0] kern_model [NTAP];
  int                     exp_sum [OUT_N];

  int unsigned            lcg_state = 81;
  string                  cur_test = "";
  int                     errors = 0;
  int                     mon_errors = 0;
  int                     test_err0 = 0;
  int                     pass_cnt = 0;
  int                     fail_cnt = 0;
  int                     cycle_cnt = 0;
  int                     total_res = 0;   // Monitor side counts.
  int                     total_done = 0;
  int                     res_base = 0;    // Snapshots at each start.
  int                     done_base = 0;
  logic                   rd_due = 1'b0;
  logic [`CONV_PIX_W-1:0] rd_exp = '0;

  tb_clock_gen u_clk (
    .clk   (clk),
    .arst_n(arst_n)
  );

  conv_engine_top uut (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_addr    (cmd_addr),
    .cmd_data    (cmd_data),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .busy        (busy),
    .result_valid(result_valid),
    .result_data (result_data),
    .done        (done)
  );

  // ********************************************************************
  // Reference model and random source
  // ********************************************************************
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // Window sum in raster order of taps.
  function automatic int window_sum(input int row, input int col);
    int acc;
    int pix;
    acc = 0;
    for (int i = 0; i < `CONV_K; i++) begin
      for (int j = 0; j < `CONV_K; j++) begin
        pix = int'(pix_model[(row + i) * `CONV_IMG_W + col + j]);
        acc += pix * int'(kern_model[i * `CONV_K + j]);
      end
    end
    return acc;
  endfunction

  // ********************************************************************
  // Check helpers
  // ********************************************************************
  task automatic check_eq(input string what, input int exp, input int act);
    assert (exp == act)
    else begin
      $display("FAILED %s %s: expected %0d actual %0d", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic report_fail(input string msg);
    $display("ERROR in %s: %s", cur_test, msg);
    errors++;
  endtask

  task automatic flag_value(input string what, input int exp, input int act);
    assert (exp == act)
    else begin
      $display("FAILED %s %s: expected %0d actual %0d", cur_test, what, exp, act);
      mon_errors++;
    end
  endtask

  task automatic flag_error(input string msg);
    $display("ERROR in %s: %s", cur_test, msg);
    mon_errors++;
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_err0 = errors + mon_errors;
  endtask

  task automatic end_test();
    int n;
    n = errors + mon_errors - test_err0;
    if (n == 0) begin
      pass_cnt++;
      $display("test %-18s pass", cur_test);
    end else begin
      fail_cnt++;
      $display("test %-18s fail, %0d errors", cur_test, n);
    end
  endtask

  // ********************************************************************
  // Stimulus, always entered 2 ns after a rising edge
  // ********************************************************************
  task automatic idle();
    @(posedge clk);
    #2;
  endtask

  task automatic send_cmd(input conv_pkg::cmd_op_t op, input int addr, input int data);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_addr  = addr[`CONV_ADDR_W-1:0];
    cmd_data  = data[`CONV_PIX_W-1:0];
    idle();
    cmd_valid = 1'b0;
  endtask

  task automatic write_pixel(input int addr, input int data);
    pix_model[addr] = data[`CONV_PIX_W-1:0];
    send_cmd(conv_pkg::OP_WR_PIXEL, addr, data);
  endtask

  task automatic write_weight(input int idx, input int data);
    kern_model[idx] = data[`CONV_PIX_W-1:0];
    send_cmd(conv_pkg::OP_WR_KERNEL, idx, data);
  endtask

  // Mode 1 adds back-to-back reads, mode 2 adds starts while busy.
  task automatic run_conv(input int mode);
    int addr;
    for (int r = 0; r < OUT_H; r++) begin
      for (int c = 0; c < OUT_W; c++) exp_sum[r * OUT_W + c] = window_sum(r, c);
    end
    res_base  = total_res;
    done_base = total_done;
    send_cmd(conv_pkg::OP_START, 0, 0);
    assert (busy) else report_fail("busy did not rise one cycle after start");
    repeat (12) idle();
    if (mode == 1) begin
      for (int i = 0; i < 40; i++) begin
        addr = int'(lcg_next() % 32'd144);
        send_cmd(conv_pkg::OP_RD_PIXEL, addr, 0);
      end
    end else if (mode == 2) begin
      send_cmd(conv_pkg::OP_START, 0, 0);
      repeat (100) idle();
      send_cmd(conv_pkg::OP_START, 0, 0);
    end
    while (total_done == done_base) idle();
    repeat (40) idle();  // Long enough to catch a stray extra run.
    check_eq("result count", OUT_N, total_res - res_base);
    check_eq("done count", 1, total_done - done_base);
    assert (!busy) else report_fail("busy still high after the run");
  endtask

  // ********************************************************************
  // Output monitor, sampled on the falling edge
  // ********************************************************************
  always @(negedge clk) begin : monitor
    int idx;
    if (arst_n) begin
      idx = total_res - res_base;
      assert (rd_valid == rd_due)
      else flag_error("rd_valid not exactly one cycle after a read strobe");
      if (rd_valid && rd_due) flag_value("read-back", int'(rd_exp), int'(rd_data));
      rd_due = cmd_valid && (cmd_op == conv_pkg::OP_RD_PIXEL);
      if (rd_due) rd_exp = pix_model[cmd_addr];
      if (result_valid) begin
        assert (idx < OUT_N) else flag_error("more than 64 results in one run");
        if (idx < OUT_N) begin
          flag_value($sformatf("result %0d", idx), exp_sum[idx], int'(result_data));
        end
        assert (done == (idx == OUT_N - 1)) else flag_error("done not on the last result");
        assert (busy == !done) else flag_error("busy does not fall together with done");
        total_res++;
      end else begin
        assert (!done) else flag_error("done without result_valid");
      end
      if (done) total_done++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, a run never finished", cycle_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    cmd_valid = 1'b0;
    cmd_op    = conv_pkg::OP_WR_PIXEL;
    cmd_addr  = '0;
    cmd_data  = '0;
    for (int i = 0; i < NPIX; i++) pix_model[i] = '0;
    for (int i = 0; i < NTAP; i++) kern_model[i] = '0;
    @(posedge arst_n);
    idle();

    begin_test("reset_state");
    assert (!result_valid && !done && !busy && !rd_valid)
    else report_fail("a status output is high after reset");
    check_eq("result_data", 0, int'(result_data));
    end_test();

    begin_test("pixel_readback");
    for (int i = 0; i < NPIX; i++) write_pixel(i, int'(lcg_next() % 32'd64));
    for (int i = 0; i < NPIX; i++) send_cmd(conv_pkg::OP_RD_PIXEL, i, 0);
    repeat (4) idle();
    end_test();

    begin_test("zero_kernel_run");
    run_conv(0);
    end_test();

    begin_test("random_run");
    for (int k = 0; k < NTAP; k++) write_weight(k, int'(lcg_next() % 32'd64));
    run_conv(0);
    end_test();

    begin_test("contention_run");
    run_conv(1);
    end_test();

    begin_test("start_while_busy");
    run_conv(2);
    end_test();

    begin_test("full_scale_run");
    for (int i = 0; i < NPIX; i++) write_pixel(i, 63);
    for (int k = 0; k < NTAP; k++) write_weight(k, 63);
    run_conv(0);
    end_test();

    $display("tests: %0d passed, %0d failed, errors: %0d",
             pass_cnt, fail_cnt, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
conv_pkg.sv
pixel_bus_if.sv
pixel_buffer.sv
host_cmd_decoder.sv
window_fetcher.sv
conv5x5_mac.sv
conv_engine_top.sv
tb_clock_gen.sv
conv_engine_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := conv_engine_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
